// File: core_bridge_pkg.sv
// bridge and system settings definitions
// settings register map, read regions, pll management map, data table

`default_nettype none

package core_bridge_pkg;

  //////////////////////////////////////////////////////////////////////
  // settings registers written by the host
  localparam logic [31:0] ADDR_ROM_TYPE       = 32'h0000_0004;
  localparam logic [31:0] ADDR_ROM_SIZE       = 32'h0000_0008;
  localparam logic [31:0] ADDR_RAM_SIZE       = 32'h0000_000C;
  localparam logic [31:0] ADDR_PAL            = 32'h0000_0010;
  localparam logic [31:0] ADDR_RESET          = 32'h0000_0050;
  localparam logic [31:0] ADDR_MULTITAP       = 32'h0000_0100;
  localparam logic [31:0] ADDR_LIGHTGUN       = 32'h0000_0104;
  localparam logic [31:0] ADDR_LIGHTGUN_SPEED = 32'h0000_0108;
  localparam logic [31:0] ADDR_VIDEO_4_3      = 32'h0000_0200;

  // read regions, by upper address bits
  localparam logic [7:0] RD_REGION_CMD  = 8'hF8;
  localparam logic [3:0] RD_REGION_SAVE = 4'h2;

  // core held in reset this long after a reset request
  localparam logic [31:0] RESET_HOLD_CYCLES = 32'h0010_0000;

  //////////////////////////////////////////////////////////////////////
  // pll reconfig management registers
  localparam logic [5:0] PLL_REG_MODE     = 6'd0;
  localparam logic [5:0] PLL_REG_MIF_ADDR = 6'd31;
  localparam logic [5:0] PLL_REG_START    = 6'd2;

  // data table slot for the save ram size
  localparam logic [9:0]  DATATABLE_SAVE_ADDR = 10'd3;
  localparam logic [31:0] SAVE_SIZE_UNIT      = 32'd1024;

endpackage

`default_nettype wire

// File: core_video_pkg.sv
// video definitions for the scaler interface
// one 24-bit word, read as a pixel or as the end-of-line mode word

`default_nettype none

package core_video_pkg;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_rgb_t;

  // sent on the first blank cycle after a line
  typedef struct packed {
    logic [8:0]  rsvd_hi;
    logic        pal;
    logic        wide_4_3;
    logic [12:0] rsvd_lo;
  } mode_word_t;

  typedef union packed {
    pixel_rgb_t pixel_rgb;
    mode_word_t mode_word;
  } video_word_u;

endpackage

`default_nettype wire

// File: core_bridge_regs.sv
// bridge settings registers
// decodes host writes into core settings, runs the reset-hold timer
// and muxes the bridge read data by address region

`timescale 1ns/1ps
`default_nettype none

module core_bridge_regs
  import core_bridge_pkg::*;
(
  input  wire         clk_74a,
  input  wire         pll_core_locked,
  input  wire  [31:0] bridge_addr,
  input  wire         bridge_wr,
  input  wire  [31:0] bridge_wr_data,
  input  wire  [31:0] cmd_rd_data,
  input  wire  [31:0] save_rd_data,
  input  wire  [31:0] hold_cycles,
  output logic [31:0] bridge_rd_data,
  output logic [7:0]  rom_type,
  output logic [3:0]  rom_size,
  output logic [3:0]  ram_size,
  output logic        pal,
  output logic        multitap_enabled,
  output logic        lightgun_enabled,
  output logic        lightgun_type,
  output logic [7:0]  lightgun_dpad_aim_speed,
  output logic        use_4_3_video,
  output logic        reset_hold
);

  logic [31:0] hold_cnt;

  //////////////////////////////////////////////////////////////////////
  // settings writes and hold counter
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rom_type                <= '0;
      rom_size                <= '0;
      ram_size                <= '0;
      pal                     <= 1'b0;
      multitap_enabled        <= 1'b0;
      lightgun_enabled        <= 1'b0;
      lightgun_type           <= 1'b0;
      lightgun_dpad_aim_speed <= '0;
      use_4_3_video           <= 1'b0;
      hold_cnt                <= '0;
    end else begin
      if (hold_cnt != 32'd0) begin
        hold_cnt <= hold_cnt - 32'd1;
      end

      // a new reset request overrides the running count
      if (bridge_wr) begin
        case (bridge_addr)
          ADDR_ROM_TYPE:       rom_type <= bridge_wr_data[7:0];
          ADDR_ROM_SIZE:       rom_size <= bridge_wr_data[3:0];
          ADDR_RAM_SIZE:       ram_size <= bridge_wr_data[3:0];
          ADDR_PAL:            pal <= bridge_wr_data[0];
          ADDR_RESET:          hold_cnt <= hold_cycles;
          ADDR_MULTITAP:       multitap_enabled <= bridge_wr_data[0];
          ADDR_LIGHTGUN: begin
            lightgun_enabled <= bridge_wr_data[0];
            lightgun_type    <= bridge_wr_data[1];
          end
          ADDR_LIGHTGUN_SPEED: lightgun_dpad_aim_speed <= bridge_wr_data[7:0];
          ADDR_VIDEO_4_3:      use_4_3_video <= bridge_wr_data[0];
          default: ;
        endcase
      end
    end
  end

  assign reset_hold = (hold_cnt != 32'd0);

  //////////////////////////////////////////////////////////////////////
  // read data mux, save region wins over command region
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr[31:24] == RD_REGION_CMD) begin
      bridge_rd_data = cmd_rd_data;
    end
    if (bridge_addr[31:28] == RD_REGION_SAVE) begin
      bridge_rd_data = save_rd_data;
    end
  end

endmodule

`default_nettype wire

// File: pll_pal_reconfig.sv
// video pll reconfiguration sequencer
// on each pal change, writes mode, mif address and start to the pll
// management port, and flags busy until the sequence completes

`timescale 1ns/1ps
`default_nettype none

module pll_pal_reconfig
  import core_bridge_pkg::*;
(
  input  wire         clk_74a,
  input  wire         pll_core_locked,
  input  wire         pal,
  input  wire         cfg_waitrequest,
  output logic        cfg_write,
  output logic [5:0]  cfg_address,
  output logic [31:0] cfg_data,
  output logic        pal_busy
);

  logic       pal_d1;
  logic       pal_d2;
  logic [2:0] state;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pal_d1      <= 1'b0;
      pal_d2      <= 1'b0;
      state       <= '0;
      cfg_write   <= 1'b0;
      cfg_address <= '0;
    end else begin
      pal_d1    <= pal;
      pal_d2    <= pal_d1;
      cfg_write <= 1'b0;

      // odd states issue a write, even states let the pll respond
      if (!cfg_waitrequest) begin
        if (state != 3'd0) begin
          state <= state + 3'd1;
        end
        case (state)
          3'd1: begin
            cfg_address <= PLL_REG_MODE;
            cfg_write   <= 1'b1;
          end
          3'd3: begin
            cfg_address <= PLL_REG_MIF_ADDR;
            cfg_write   <= 1'b1;
          end
          3'd5: begin
            cfg_address <= PLL_REG_START;
            cfg_write   <= 1'b1;
            state       <= 3'd0;
          end
          default: ;
        endcase
      end

      // a fresh change restarts the sequence
      if (pal_d1 != pal_d2) begin
        state <= 3'd1;
      end
    end
  end

  // only writes of zero are needed for the preloaded mif
  assign cfg_data = 32'd0;

  assign pal_busy = (state != 3'd0) || cfg_waitrequest || cfg_write;

endmodule

`default_nettype wire

// File: save_slot_ctrl.sv
// save slot tracking
// flags save activity between a data slot request and completion,
// and reports the save ram size through the data table

`timescale 1ns/1ps
`default_nettype none

module save_slot_ctrl
  import core_bridge_pkg::*;
(
  input  wire         clk_74a,
  input  wire         pll_core_locked,
  input  wire         dataslot_requestread,
  input  wire         dataslot_requestwrite,
  input  wire         dataslot_allcomplete,
  input  wire  [3:0]  sram_size,
  output logic        save_busy,
  output logic        datatable_wren,
  output logic [9:0]  datatable_addr,
  output logic [31:0] datatable_data
);

  logic allcomplete_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      save_busy        <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;
      // request wins over a completion in the same cycle
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_busy <= 1'b1;
      end else if (dataslot_allcomplete && !allcomplete_prev) begin
        save_busy <= 1'b0;
      end
    end
  end

  // sram_size is a power of two in kilobytes, zero means no save ram
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      datatable_data <= '0;
    end else begin
      datatable_wren <= 1'b1;
      datatable_addr <= DATATABLE_SAVE_ADDR;
      datatable_data <= (sram_size != 4'd0) ? (SAVE_SIZE_UNIT << sram_size) : 32'd0;
    end
  end

endmodule

`default_nettype wire

// File: video_out_fmt.sv
// scaler video formatter
// registers pixels with data enable, turns sync into single-cycle
// pulses and appends the mode word after each active line

`timescale 1ns/1ps
`default_nettype none

module video_out_fmt
  import core_video_pkg::*;
(
  input  wire          clk_74a,
  input  wire          pll_core_locked,
  input  wire          h_blank,
  input  wire          v_blank,
  input  wire          hsync,
  input  wire          vsync,
  input  video_word_u  rgb_in,
  input  wire          pal,
  input  wire          use_4_3_video,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs,
  output video_word_u  video_rgb
);

  logic        de;
  logic        de_prev;
  logic        hs_prev;
  logic        vs_prev;
  video_word_u eol_word;

  assign de = !(h_blank || v_blank);

  always_comb begin
    eol_word                    = '0;
    eol_word.mode_word.pal      = pal;
    eol_word.mode_word.wide_4_3 = use_4_3_video;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
    end else begin
      de_prev  <= de;
      hs_prev  <= hsync;
      vs_prev  <= vsync;
      video_de <= de;
      // rising edges only
      video_hs <= hsync && !hs_prev;
      video_vs <= vsync && !vs_prev;

      video_rgb <= '0;
      if (de) begin
        video_rgb.pixel_rgb <= rgb_in.pixel_rgb;
      end else if (de_prev) begin
        // previous cycle held the last pixel of the line
        video_rgb <= eol_word;
      end
    end
  end

endmodule

`default_nettype wire

// File: snes_pocket_top.sv
// snes user-core glue top level
// wires the bridge settings, pll sequencer, save tracking and video
// formatter together, and forms the core reset

`timescale 1ns/1ps
`default_nettype none

module snes_pocket_top
  import core_bridge_pkg::*;
  import core_video_pkg::*;
#(
  parameter logic [31:0] hold_cycles = RESET_HOLD_CYCLES
) (
  input  wire          clk_74a,
  input  wire          pll_core_locked,
  // bridge bus
  input  wire   [31:0] bridge_addr,
  input  wire          bridge_wr,
  input  wire   [31:0] bridge_wr_data,
  output logic  [31:0] bridge_rd_data,
  input  wire   [31:0] cmd_rd_data,
  input  wire   [31:0] save_rd_data,
  // settings to the core
  output logic  [7:0]  rom_type,
  output logic  [3:0]  rom_size,
  output logic  [3:0]  ram_size,
  output logic         pal,
  output logic         multitap_enabled,
  output logic         lightgun_enabled,
  output logic         lightgun_type,
  output logic  [7:0]  lightgun_dpad_aim_speed,
  output logic         use_4_3_video,
  // pll management port
  input  wire          cfg_waitrequest,
  output logic         cfg_write,
  output logic  [5:0]  cfg_address,
  output logic  [31:0] cfg_data,
  // data slots
  input  wire          dataslot_requestread,
  input  wire          dataslot_requestwrite,
  input  wire          dataslot_allcomplete,
  input  wire   [3:0]  sram_size,
  output logic         save_busy,
  output logic         datatable_wren,
  output logic  [9:0]  datatable_addr,
  output logic  [31:0] datatable_data,
  // video from core and to scaler
  input  wire          h_blank,
  input  wire          v_blank,
  input  wire          hsync,
  input  wire          vsync,
  input  video_word_u  rgb_in,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs,
  output video_word_u  video_rgb,
  output logic         core_reset
);

  logic reset_hold;
  logic pal_busy;

  core_bridge_regs i_core_bridge_regs (
    .clk_74a                 (clk_74a),
    .pll_core_locked         (pll_core_locked),
    .bridge_addr             (bridge_addr),
    .bridge_wr               (bridge_wr),
    .bridge_wr_data          (bridge_wr_data),
    .cmd_rd_data             (cmd_rd_data),
    .save_rd_data            (save_rd_data),
    .hold_cycles             (hold_cycles),
    .bridge_rd_data          (bridge_rd_data),
    .rom_type                (rom_type),
    .rom_size                (rom_size),
    .ram_size                (ram_size),
    .pal                     (pal),
    .multitap_enabled        (multitap_enabled),
    .lightgun_enabled        (lightgun_enabled),
    .lightgun_type           (lightgun_type),
    .lightgun_dpad_aim_speed (lightgun_dpad_aim_speed),
    .use_4_3_video           (use_4_3_video),
    .reset_hold              (reset_hold)
  );

  pll_pal_reconfig i_pll_pal_reconfig (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .pal             (pal),
    .cfg_waitrequest (cfg_waitrequest),
    .cfg_write       (cfg_write),
    .cfg_address     (cfg_address),
    .cfg_data        (cfg_data),
    .pal_busy        (pal_busy)
  );

  save_slot_ctrl i_save_slot_ctrl (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .sram_size             (sram_size),
    .save_busy             (save_busy),
    .datatable_wren        (datatable_wren),
    .datatable_addr        (datatable_addr),
    .datatable_data        (datatable_data)
  );

  video_out_fmt i_video_out_fmt (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .h_blank         (h_blank),
    .v_blank         (v_blank),
    .hsync           (hsync),
    .vsync           (vsync),
    .rgb_in          (rgb_in),
    .pal             (pal),
    .use_4_3_video   (use_4_3_video),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

  // core stays in reset while the pll is unlocked, a hold runs or the pll is reprogrammed
  assign core_reset = !pll_core_locked || reset_hold || pal_busy;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock and reset source
// 100 ns clock, pll lock held low for the first five cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_74a,
  output logic pll_core_locked
);

  initial begin
    clk_74a = 1'b0;
    forever #50 clk_74a = ~clk_74a;
  end

  // lock comes up just after the fifth rising edge
  initial begin
    pll_core_locked = 1'b0;
    repeat (5) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_snes_pocket_top.sv
// testbench for the snes user-core glue top level
// covers bridge settings and read mux, reset hold, pll reprogramming,
// save tracking with the data table, and the scaler video formatter

`timescale 1ns/1ps
`default_nettype none

module tb_snes_pocket_top
  import core_bridge_pkg::*;
  import core_video_pkg::*;
();

  localparam logic [31:0] SEED = 32'hae70_e374;
  localparam int HOLD_CYCLES = 40;
  // the tests take roughly 900 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  wire clk_74a;
  wire pll_core_locked;

  logic [31:0] bridge_addr, bridge_wr_data, cmd_rd_data, save_rd_data, bridge_rd_data;
  logic        bridge_wr;
  logic [7:0]  rom_type, lightgun_dpad_aim_speed;
  logic [3:0]  rom_size, ram_size, sram_size;
  logic        pal, multitap_enabled, lightgun_enabled, lightgun_type, use_4_3_video;
  logic        cfg_waitrequest, cfg_write;
  logic [5:0]  cfg_address;
  logic [31:0] cfg_data, datatable_data;
  logic        dataslot_requestread, dataslot_requestwrite, dataslot_allcomplete;
  logic        save_busy, datatable_wren;
  logic [9:0]  datatable_addr;
  logic        h_blank, v_blank, hsync, vsync;
  logic        video_de, video_hs, video_vs, core_reset;
  video_word_u rgb_in, video_rgb;

  // expected register state as written by the host
  logic [7:0]  sh_rom_type, sh_lg_speed;
  logic [3:0]  sh_rom_size, sh_ram_size;
  logic        sh_pal, sh_multitap, sh_lg_en, sh_lg_type, sh_w43;

  logic [31:0] rng;
  logic [31:0] wait_rng;
  int          cycle_count;

  // video reference state
  logic        ref_valid, ref_de_prev, ref_hs_prev, ref_vs_prev, de_now;
  logic        exp_de, exp_hs, exp_vs;
  video_word_u exp_rgb;

  tb_clk_gen i_tb_clk_gen (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked)
  );

  snes_pocket_top #(
    .hold_cycles (HOLD_CYCLES)
  ) i_snes_pocket_top (.*);

  //////////////////////////////////////////////////////////////////////
  // helpers and reference models

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // save region (upper nibble 2) wins over command region (upper byte f8)
  function automatic logic [31:0] read_mux_ref(input logic [31:0] addr,
      input logic [31:0] cmd, input logic [31:0] save);
    if (addr[31:28] == 4'h2) begin
      return save;
    end
    if (addr[31:24] == 8'hF8) begin
      return cmd;
    end
    return 32'd0;
  endfunction

  // save ram bytes are 1 KiB times two to the size code
  function automatic logic [31:0] table_word_ref(input logic [3:0] size);
    if (size == 4'd0) begin
      return 32'd0;
    end
    return 32'd1024 * (32'd1 << size);
  endfunction

  // mode word holds pal at bit 14 and wide 4:3 at bit 13
  function automatic logic [23:0] video_word_ref(input logic de_cur, input logic de_last,
      input logic [23:0] pix, input logic pal_v, input logic wide_v);
    if (de_cur) begin
      return pix;
    end
    if (de_last) begin
      return {9'd0, pal_v, wide_v, 13'd0};
    end
    return 24'd0;
  endfunction

  function automatic logic [31:0] pick_setting_addr(input int idx);
    case (idx)
      0: return ADDR_ROM_TYPE;
      1: return ADDR_ROM_SIZE;
      2: return ADDR_RAM_SIZE;
      3: return ADDR_PAL;
      4: return ADDR_RESET;
      5: return ADDR_MULTITAP;
      6: return ADDR_LIGHTGUN;
      7: return ADDR_LIGHTGUN_SPEED;
      8: return ADDR_VIDEO_4_3;
      default: return 32'h0000_0300;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run aborted");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle;
    @(posedge clk_74a);
    #1;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    next_cycle();
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    next_cycle();
    bridge_wr = 1'b0;
    case (addr)
      ADDR_ROM_TYPE:       sh_rom_type = data[7:0];
      ADDR_ROM_SIZE:       sh_rom_size = data[3:0];
      ADDR_RAM_SIZE:       sh_ram_size = data[3:0];
      ADDR_PAL:            sh_pal = data[0];
      ADDR_MULTITAP:       sh_multitap = data[0];
      ADDR_LIGHTGUN: begin
        sh_lg_en   = data[0];
        sh_lg_type = data[1];
      end
      ADDR_LIGHTGUN_SPEED: sh_lg_speed = data[7:0];
      ADDR_VIDEO_4_3:      sh_w43 = data[0];
      default: ;
    endcase
  endtask

  task automatic check_settings;
    compare_value("rom_type", rom_type, sh_rom_type);
    compare_value("rom_size", rom_size, sh_rom_size);
    compare_value("ram_size", ram_size, sh_ram_size);
    compare_value("pal", pal, sh_pal);
    compare_value("multitap_enabled", multitap_enabled, sh_multitap);
    compare_value("lightgun_enabled", lightgun_enabled, sh_lg_en);
    compare_value("lightgun_type", lightgun_type, sh_lg_type);
    compare_value("lightgun_dpad_aim_speed", lightgun_dpad_aim_speed, sh_lg_speed);
    compare_value("use_4_3_video", use_4_3_video, sh_w43);
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    @(negedge clk_74a);
    while (core_reset) begin
      n++;
      if (n > 200) begin
        abort_run("core reset stayed high while waiting for the core to go idle");
      end
      @(negedge clk_74a);
    end
  endtask

  // one pal change expects mode, mif address and start writes under core reset
  task automatic check_pal_sequence;
    logic [5:0] exp_addr [3];
    int         seen;
    int         c;
    logic       started;
    exp_addr[0] = PLL_REG_MODE;
    exp_addr[1] = PLL_REG_MIF_ADDR;
    exp_addr[2] = PLL_REG_START;
    seen    = 0;
    started = 1'b0;
    c       = 0;
    while (!(seen == 3 && !core_reset)) begin
      @(negedge clk_74a);
      if (core_reset) begin
        started = 1'b1;
      end
      if (!started && c >= 3) begin
        abort_run("core reset did not rise within 3 cycles of a pal change");
      end
      if (seen > 0 && seen < 3) begin
        compare_value("core_reset", core_reset, 1'b1);
      end
      if (cfg_write) begin
        if (seen == 3) begin
          abort_run("more than three pll writes for one pal change");
        end
        compare_value("core_reset", core_reset, 1'b1);
        compare_value("cfg_address", cfg_address, exp_addr[seen]);
        compare_value("cfg_data", cfg_data, 32'd0);
        seen++;
      end
      c++;
      if (c > 100) begin
        abort_run("pll reconfiguration sequence did not complete");
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // pll side stalls the sequencer for 0 to 5 cycles after each write

  initial begin : waitrequest_responder
    int unsigned wait_len;
    cfg_waitrequest = 1'b0;
    wait_rng = xorshift32(SEED);
    forever begin
      next_cycle();
      if (cfg_write) begin
        wait_rng = xorshift32(wait_rng);
        wait_len = wait_rng % 6;
        if (wait_len != 0) begin
          cfg_waitrequest = 1'b1;
          repeat (wait_len) @(posedge clk_74a);
          #1;
          cfg_waitrequest = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // video expectation formed at one falling edge and checked at the next

  always @(negedge clk_74a) begin
    if (!pll_core_locked) begin
      ref_valid   = 1'b0;
      ref_de_prev = 1'b0;
      ref_hs_prev = 1'b0;
      ref_vs_prev = 1'b0;
    end else begin
      if (ref_valid) begin
        compare_value("video_de", video_de, exp_de);
        compare_value("video_hs", video_hs, exp_hs);
        compare_value("video_vs", video_vs, exp_vs);
        compare_value("video_rgb", video_rgb, exp_rgb);
      end
      de_now      = !(h_blank || v_blank);
      exp_de      = de_now;
      exp_hs      = hsync && !ref_hs_prev;
      exp_vs      = vsync && !ref_vs_prev;
      exp_rgb     = video_word_ref(de_now, ref_de_prev, rgb_in, sh_pal, sh_w43);
      ref_de_prev = de_now;
      ref_hs_prev = hsync;
      ref_vs_prev = vsync;
      ref_valid   = 1'b1;
    end
  end

  always @(posedge clk_74a) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin : main_sequence
    int i;
    int cnt;
    cycle_count = 0;
    rng = SEED;
    {bridge_addr, bridge_wr_data, cmd_rd_data, save_rd_data} = '0;
    bridge_wr = 1'b0;
    {dataslot_requestread, dataslot_requestwrite, dataslot_allcomplete} = '0;
    sram_size = '0;
    h_blank = 1'b1;
    v_blank = 1'b1;
    hsync = 1'b0;
    vsync = 1'b0;
    rgb_in = '0;
    {sh_rom_type, sh_lg_speed, sh_rom_size, sh_ram_size} = '0;
    {sh_pal, sh_multitap, sh_lg_en, sh_lg_type, sh_w43} = '0;

    wait (pll_core_locked === 1'b1);
    @(negedge clk_74a);
    check_settings();
    compare_value("save_busy", save_busy, 1'b0);
    compare_value("cfg_write", cfg_write, 1'b0);

    // settings writes with an unmapped address among them
    for (i = 0; i < 40; i++) begin
      rng = xorshift32(rng);
      cnt = rng % 10;
      rng = xorshift32(rng);
      bus_write(pick_setting_addr(cnt), rng);
      @(negedge clk_74a);
      check_settings();
    end

    // read mux over command, save and other regions
    for (i = 0; i < 40; i++) begin
      next_cycle();
      rng = xorshift32(rng);
      case (rng % 3)
        0: bridge_addr = {8'hF8, rng[31:8]};
        1: bridge_addr = {4'h2, rng[31:4]};
        default: bridge_addr = xorshift32(rng ^ 32'h0000_ffff);
      endcase
      rng = xorshift32(rng);
      cmd_rd_data = rng;
      rng = xorshift32(rng);
      save_rd_data = rng;
      @(negedge clk_74a);
      compare_value("bridge_rd_data", bridge_rd_data,
                    read_mux_ref(bridge_addr, cmd_rd_data, save_rd_data));
    end

    // reset hold
    wait_idle();
    bus_write(ADDR_RESET, 32'd0);
    cnt = 0;
    @(negedge clk_74a);
    while (core_reset && cnt < 100) begin
      cnt++;
      @(negedge clk_74a);
    end
    compare_value("core_reset high cycles", cnt, HOLD_CYCLES);

    // pll reprogramming on each pal change
    for (i = 0; i < 4; i++) begin
      wait_idle();
      bus_write(ADDR_PAL, {31'd0, !sh_pal});
      check_pal_sequence();
    end

    // save activity flag
    next_cycle();
    dataslot_requestread = 1'b1;
    next_cycle();
    dataslot_requestread = 1'b0;
    @(negedge clk_74a);
    compare_value("save_busy", save_busy, 1'b1);
    next_cycle();
    dataslot_allcomplete = 1'b1;
    next_cycle();
    @(negedge clk_74a);
    compare_value("save_busy", save_busy, 1'b0);
    // all-complete stays high, so only a new edge may clear
    next_cycle();
    dataslot_requestwrite = 1'b1;
    next_cycle();
    dataslot_requestwrite = 1'b0;
    for (i = 0; i < 4; i++) begin
      @(negedge clk_74a);
      compare_value("save_busy", save_busy, 1'b1);
      next_cycle();
    end
    dataslot_allcomplete = 1'b0;
    next_cycle();
    // request wins over a completion edge in the same cycle
    dataslot_allcomplete = 1'b1;
    dataslot_requestread = 1'b1;
    next_cycle();
    dataslot_requestread = 1'b0;
    @(negedge clk_74a);
    compare_value("save_busy", save_busy, 1'b1);
    next_cycle();
    dataslot_allcomplete = 1'b0;
    next_cycle();
    dataslot_allcomplete = 1'b1;
    next_cycle();
    @(negedge clk_74a);
    compare_value("save_busy", save_busy, 1'b0);

    // data table word for every save size
    for (i = 0; i < 16; i++) begin
      next_cycle();
      sram_size = i[3:0];
      next_cycle();
      @(negedge clk_74a);
      compare_value("datatable_data", datatable_data, table_word_ref(i[3:0]));
      compare_value("datatable_addr", datatable_addr, 10'd3);
      compare_value("datatable_wren", datatable_wren, 1'b1);
    end

    // pal and 4:3 stay opposite and swap values between two video passes
    bus_write(ADDR_VIDEO_4_3, {31'd0, !sh_pal});
    for (cnt = 0; cnt < 2; cnt++) begin
      bus_write(ADDR_VIDEO_4_3, {31'd0, !sh_w43});
      bus_write(ADDR_PAL, {31'd0, !sh_pal});
      for (i = 0; i < 200; i++) begin
        next_cycle();
        rng = xorshift32(rng);
        h_blank = (rng[1:0] == 2'd0);
        v_blank = (rng[7:3] == 5'd0);
        hsync   = rng[8];
        vsync   = rng[9];
        rng = xorshift32(rng);
        rgb_in = rng[23:0];
      end
    end
    next_cycle();
    h_blank = 1'b1;
    v_blank = 1'b1;
    repeat (3) next_cycle();
    @(negedge clk_74a);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
core_bridge_pkg.sv
core_video_pkg.sv
core_bridge_regs.sv
pll_pal_reconfig.sv
save_slot_ctrl.sv
video_out_fmt.sv
snes_pocket_top.sv
tb_clk_gen.sv
tb_snes_pocket_top.sv
